/* common/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// geometry of the data cache
`define DCACHE_SETS 8
`define DCACHE_WAYS 2

// address and data widths
`define DCACHE_ADDR_W 32
`define DCACHE_WORD_W 32

// address split, tag | index | byte offset within the block
`define DCACHE_INDEX_W 3
// two words of four bytes per block
`define DCACHE_OFFSET_W 3
`define DCACHE_TAG_W 26

`endif

/* common/dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

   // data word, also used for byte addresses
   typedef logic [`DCACHE_WORD_W-1:0] word_t;

   // block tag and set index
   typedef logic [`DCACHE_TAG_W-1:0] tag_t;
   typedef logic [`DCACHE_INDEX_W-1:0] index_t;

   // state of one way in one set
   typedef struct packed {
      tag_t tag;
      logic valid;
      logic dirty;
      // word at offset 4
      word_t dat1;
      // word at offset 0
      word_t dat0;
   } line_t;

   // controller states
   // WB* write back the victim, FILL* read the new block
   // SCAN and FLUSH* walk the array on halt
   typedef enum logic [3:0] {
      IDLE,
      WB0,
      WB1,
      FILL0,
      FILL1,
      SCAN,
      FLUSH0,
      FLUSH1,
      HALTED
   } ctrl_state_e;

   // request on the memory side
   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_READ,
      MEM_WRITE
   } mem_op_e;

endpackage

/* common/cache_array_if.sv */
`include "dcache_settings.svh"

interface cache_array_if;

   // set being accessed this cycle
   dcache_pkg::index_t index;

   // both ways of the addressed set
   dcache_pkg::line_t [`DCACHE_WAYS-1:0] lines;
   // least recently used way of the addressed set
   logic lru;

   // line write, one enable per way, applied at the next edge
   logic [`DCACHE_WAYS-1:0] wen;
   dcache_pkg::line_t wline;

   // lru bit update for the addressed set
   logic lru_wen;
   logic lru_wval;

   modport store (
      input index, wen, wline, lru_wen, lru_wval,
      output lines, lru
   );

   modport lookup (
      input lines, lru
   );

   // controller also reads the lines for write-back and flush data
   modport controller (
      output index, wen, wline, lru_wen, lru_wval,
      input lines, lru
   );

endinterface

/* dcache/dcache_store.sv */
`include "dcache_settings.svh"

module dcache_store (
   input logic CLK,
   input logic nRST,
   cache_array_if.store arr
);

   // one line per way and set
   dcache_pkg::line_t ways [`DCACHE_WAYS][`DCACHE_SETS];

   // one bit per set, names the least recently used way
   logic [`DCACHE_SETS-1:0] lru_bits;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         // every line invalid and clean after reset
         for (int w = 0; w < `DCACHE_WAYS; w++)
         begin
            for (int s = 0; s < `DCACHE_SETS; s++)
            begin
               ways[w][s] <= '0;
            end
         end
         lru_bits <= '0;
      end
      else
      begin
         // per-way line write into the addressed set
         for (int w = 0; w < `DCACHE_WAYS; w++)
         begin
            if (arr.wen[w])
            begin
               ways[w][arr.index] <= arr.wline;
            end
         end
         // lru bit update
         if (arr.lru_wen)
         begin
            lru_bits[arr.index] <= arr.lru_wval;
         end
      end
   end

   // read port, both ways of the addressed set
   always_comb
   begin
      for (int w = 0; w < `DCACHE_WAYS; w++)
      begin
         arr.lines[w] = ways[w][arr.index];
      end
   end

   assign arr.lru = lru_bits[arr.index];

endmodule

/* dcache/dcache_lookup.sv */
`include "dcache_settings.svh"

module dcache_lookup (
   input dcache_pkg::word_t dmemaddr,
   cache_array_if.lookup arr,
   output logic hit,
   output logic hit_way,
   output dcache_pkg::word_t hit_word,
   output logic victim_dirty
);

   // request tag, top bits of the address
   dcache_pkg::tag_t req_tag;
   // word select, bit 2 of the byte offset
   logic word_sel;
   // per-way tag match on a valid line
   logic [`DCACHE_WAYS-1:0] way_match;
   // line chosen for the read data
   dcache_pkg::line_t sel_line;
   // lru way is the replacement victim
   dcache_pkg::line_t victim_line;

   assign req_tag = dmemaddr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
   assign word_sel = dmemaddr[`DCACHE_OFFSET_W-1];

   // tag compare against both ways
   always_comb
   begin
      for (int w = 0; w < `DCACHE_WAYS; w++)
      begin
         way_match[w] = arr.lines[w].valid && (arr.lines[w].tag == req_tag);
      end
   end

   assign hit = |way_match;
   // way 1 when it matches, otherwise way 0
   assign hit_way = way_match[1];

   assign sel_line = arr.lines[hit_way];
   assign hit_word = word_sel ? sel_line.dat1 : sel_line.dat0;

   // write-back is needed only for a valid and dirty victim
   assign victim_line = arr.lines[arr.lru];
   assign victim_dirty = victim_line.valid && victim_line.dirty;

endmodule

/* dcache/dcache_controller.sv */
`include "dcache_settings.svh"

module dcache_controller (
   input logic CLK,
   input logic nRST,
   input logic dmemREN,
   input logic dmemWEN,
   input logic halt,
   input dcache_pkg::word_t dmemaddr,
   input dcache_pkg::word_t dmemstore,
   input logic hit,
   input logic hit_way,
   input logic victim_dirty,
   input dcache_pkg::word_t dload,
   input logic dwait,
   cache_array_if.controller arr,
   output dcache_pkg::mem_op_e mem_op,
   output dcache_pkg::word_t daddr,
   output dcache_pkg::word_t dstore,
   output logic dhit,
   output logic flushed
);

   dcache_pkg::ctrl_state_e state;
   dcache_pkg::ctrl_state_e next_state;

   // flush slot, low bits are the set, next bit the way, top bit marks the end
   logic [`DCACHE_INDEX_W+1:0] slot;
   logic [`DCACHE_INDEX_W+1:0] next_slot;

   // fields of the processor request
   dcache_pkg::tag_t req_tag;
   dcache_pkg::index_t req_index;
   logic req_word;
   logic request;

   // array is addressed by the slot counter during the halt scan
   logic scanning;
   // victim way on a miss, slot way during the scan
   logic src_way;
   dcache_pkg::line_t src_line;
   dcache_pkg::line_t hit_line;

   // memory address parts
   dcache_pkg::tag_t mem_tag;
   logic mem_word;

   assign req_tag = dmemaddr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
   assign req_index = dmemaddr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
   assign req_word = dmemaddr[`DCACHE_OFFSET_W-1];
   assign request = dmemREN || dmemWEN;

   assign scanning = state inside {dcache_pkg::SCAN, dcache_pkg::FLUSH0,
                                   dcache_pkg::FLUSH1, dcache_pkg::HALTED};

   assign arr.index = scanning ? slot[`DCACHE_INDEX_W-1:0] : req_index;
   assign src_way = scanning ? slot[`DCACHE_INDEX_W] : arr.lru;
   assign src_line = arr.lines[src_way];
   assign hit_line = arr.lines[hit_way];

   // hits are answered in the same cycle, only while idle
   assign dhit = (state == dcache_pkg::IDLE) && request && hit;
   assign flushed = (state == dcache_pkg::HALTED);

   // memory request per state
   always_comb
   begin
      mem_op = dcache_pkg::MEM_NONE;
      mem_tag = req_tag;
      mem_word = 1'b0;
      case (state)
         dcache_pkg::WB0, dcache_pkg::FLUSH0:
         begin
            mem_op = dcache_pkg::MEM_WRITE;
            mem_tag = src_line.tag;
         end
         dcache_pkg::WB1, dcache_pkg::FLUSH1:
         begin
            mem_op = dcache_pkg::MEM_WRITE;
            mem_tag = src_line.tag;
            mem_word = 1'b1;
         end
         // fill reads the block of the request tag
         dcache_pkg::FILL0:
         begin
            mem_op = dcache_pkg::MEM_READ;
         end
         dcache_pkg::FILL1:
         begin
            mem_op = dcache_pkg::MEM_READ;
            mem_word = 1'b1;
         end
         default:
         begin
            mem_op = dcache_pkg::MEM_NONE;
         end
      endcase
   end

   // block address with the word select, bytes 0
   assign daddr = {mem_tag, arr.index, mem_word, {(`DCACHE_OFFSET_W-1){1'b0}}};
   assign dstore = mem_word ? src_line.dat1 : src_line.dat0;

   // next state and array writes
   always_comb
   begin
      next_state = state;
      next_slot = slot;
      arr.wen = '0;
      arr.wline = src_line;
      arr.lru_wen = 1'b0;
      // the way just used becomes most recent
      arr.lru_wval = ~hit_way;
      case (state)
         dcache_pkg::IDLE:
         begin
            if (request && hit)
            begin
               arr.lru_wen = 1'b1;
               // write hit updates the word and marks the line dirty
               if (dmemWEN)
               begin
                  arr.wen[hit_way] = 1'b1;
                  arr.wline = hit_line;
                  arr.wline.dirty = 1'b1;
                  if (req_word)
                  begin
                     arr.wline.dat1 = dmemstore;
                  end
                  else
                  begin
                     arr.wline.dat0 = dmemstore;
                  end
               end
            end
            if (halt)
            begin
               next_state = dcache_pkg::SCAN;
               next_slot = '0;
            end
            else if (request && !hit)
            begin
               if (victim_dirty)
               begin
                  next_state = dcache_pkg::WB0;
               end
               else
               begin
                  next_state = dcache_pkg::FILL0;
               end
            end
         end
         dcache_pkg::WB0:
         begin
            if (!dwait)
            begin
               next_state = dcache_pkg::WB1;
            end
         end
         dcache_pkg::WB1:
         begin
            if (!dwait)
            begin
               next_state = dcache_pkg::FILL0;
            end
         end
         dcache_pkg::FILL0:
         begin
            // first word goes straight into the victim, kept invalid until the tag lands
            if (!dwait)
            begin
               arr.wen[src_way] = 1'b1;
               arr.wline.valid = 1'b0;
               arr.wline.dirty = 1'b0;
               arr.wline.dat0 = dload;
               next_state = dcache_pkg::FILL1;
            end
         end
         dcache_pkg::FILL1:
         begin
            if (!dwait)
            begin
               arr.wen[src_way] = 1'b1;
               arr.wline.tag = req_tag;
               arr.wline.valid = 1'b1;
               arr.wline.dirty = 1'b0;
               arr.wline.dat1 = dload;
               // other way becomes lru
               arr.lru_wen = 1'b1;
               arr.lru_wval = ~src_way;
               next_state = dcache_pkg::IDLE;
            end
         end
         dcache_pkg::SCAN:
         begin
            // top slot bit set means all 16 slots done
            if (slot[`DCACHE_INDEX_W+1])
            begin
               next_state = dcache_pkg::HALTED;
            end
            else if (src_line.valid && src_line.dirty)
            begin
               next_state = dcache_pkg::FLUSH0;
            end
            else
            begin
               next_slot = slot + 1'b1;
            end
         end
         dcache_pkg::FLUSH0:
         begin
            if (!dwait)
            begin
               next_state = dcache_pkg::FLUSH1;
            end
         end
         dcache_pkg::FLUSH1:
         begin
            // block is in memory, clear dirty and move on
            if (!dwait)
            begin
               arr.wen[src_way] = 1'b1;
               arr.wline.dirty = 1'b0;
               next_slot = slot + 1'b1;
               next_state = dcache_pkg::SCAN;
            end
         end
         default:
         begin
            // HALTED holds until reset
            next_state = state;
         end
      endcase
   end

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state <= dcache_pkg::IDLE;
         slot <= '0;
      end
      else
      begin
         state <= next_state;
         slot <= next_slot;
      end
   end

endmodule

/* design/dcache.sv */
module dcache (
   input logic CLK,
   input logic nRST,

   // processor side
   input logic dmemREN,
   input logic dmemWEN,
   input logic halt,
   input dcache_pkg::word_t dmemaddr,
   input dcache_pkg::word_t dmemstore,
   output logic dhit,
   output dcache_pkg::word_t dmemload,
   output logic flushed,

   // memory side
   output logic dREN,
   output logic dWEN,
   output dcache_pkg::word_t daddr,
   output dcache_pkg::word_t dstore,
   input dcache_pkg::word_t dload,
   input logic dwait
);

   // array port shared by the three blocks
   cache_array_if arr ();

   // lookup results
   logic hit;
   logic hit_way;
   logic victim_dirty;
   dcache_pkg::word_t hit_word;

   // memory request from the controller
   dcache_pkg::mem_op_e mem_op;

   dcache_store i_store (
      .CLK (CLK),
      .nRST(nRST),
      .arr (arr)
   );

   dcache_lookup i_lookup (
      .dmemaddr    (dmemaddr),
      .arr         (arr),
      .hit         (hit),
      .hit_way     (hit_way),
      .hit_word    (hit_word),
      .victim_dirty(victim_dirty)
   );

   dcache_controller i_controller (
      .CLK         (CLK),
      .nRST        (nRST),
      .dmemREN     (dmemREN),
      .dmemWEN     (dmemWEN),
      .halt        (halt),
      .dmemaddr    (dmemaddr),
      .dmemstore   (dmemstore),
      .hit         (hit),
      .hit_way     (hit_way),
      .victim_dirty(victim_dirty),
      .dload       (dload),
      .dwait       (dwait),
      .arr         (arr),
      .mem_op      (mem_op),
      .daddr       (daddr),
      .dstore      (dstore),
      .dhit        (dhit),
      .flushed     (flushed)
   );

   // read data is valid whenever dhit is high
   assign dmemload = hit_word;

   // opcode to memory strobes
   assign dREN = (mem_op == dcache_pkg::MEM_READ);
   assign dWEN = (mem_op == dcache_pkg::MEM_WRITE);

endmodule

/* verification/dcache_assertions.sv */
module dcache_assertions (
   input logic CLK,
   input logic nRST,
   input dcache_pkg::ctrl_state_e state,
   input dcache_pkg::mem_op_e mem_op,
   input dcache_pkg::word_t daddr,
   input dcache_pkg::word_t dstore,
   input logic dwait,
   input logic flushed
);

   // read and write strobes come from one opcode, only the three legal codes
   a_strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
      mem_op inside {dcache_pkg::MEM_NONE, dcache_pkg::MEM_READ, dcache_pkg::MEM_WRITE})
      else $error("read and write strobes both requested");

   // request held with dwait high keeps state, opcode, address and data
   a_request_stable: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_op != dcache_pkg::MEM_NONE) && dwait |=>
         $stable(state) && (mem_op == $past(mem_op)) && $stable(daddr) && $stable(dstore))
      else $error("memory request changed while dwait was high");

   // flushed never drops before reset
   a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |=> flushed)
      else $error("flushed dropped");

   // no memory traffic once the flush is done
   a_flushed_quiet: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |-> (mem_op == dcache_pkg::MEM_NONE))
      else $error("memory request issued after flushed");

endmodule

/* verification/dcache_tb.sv */
module dcache_tb;

   // request kinds in the stimulus table
   typedef enum logic [1:0] {
      OP_READ,
      OP_WRITE,
      OP_HALT
   } tb_op_e;

   // cycles allowed for any single wait
   localparam int TIMEOUT_CYCLES = 200;
   // memory starts out as the address xor this constant
   localparam logic [31:0] MEM_PATTERN = 32'h5A5A_C3C3;

   logic CLK;
   logic nRST;
   logic dmemREN;
   logic dmemWEN;
   logic halt;
   dcache_pkg::word_t dmemaddr;
   dcache_pkg::word_t dmemstore;
   logic dhit;
   dcache_pkg::word_t dmemload;
   logic flushed;
   logic dREN;
   logic dWEN;
   dcache_pkg::word_t daddr;
   dcache_pkg::word_t dstore;
   dcache_pkg::word_t dload;
   logic dwait;

   // memory model contents, only written words are stored
   dcache_pkg::word_t mem_words [dcache_pkg::word_t];
   // expected memory image, last value written by the processor
   dcache_pkg::word_t shadow [dcache_pkg::word_t];

   // stimulus table, one row per step across the queues
   string step_name [$];
   tb_op_e step_op [$];
   dcache_pkg::word_t step_addr [$];
   dcache_pkg::word_t step_data [$];
   // memory traffic expected before dhit or flushed
   logic step_mem [$];

   dcache i_dut (
      .CLK      (CLK),
      .nRST     (nRST),
      .dmemREN  (dmemREN),
      .dmemWEN  (dmemWEN),
      .halt     (halt),
      .dmemaddr (dmemaddr),
      .dmemstore(dmemstore),
      .dhit     (dhit),
      .dmemload (dmemload),
      .flushed  (flushed),
      .dREN     (dREN),
      .dWEN     (dWEN),
      .daddr    (daddr),
      .dstore   (dstore),
      .dload    (dload),
      .dwait    (dwait)
   );

   bind dcache_controller dcache_assertions i_assertions (
      .CLK    (CLK),
      .nRST   (nRST),
      .state  (state),
      .mem_op (mem_op),
      .daddr  (daddr),
      .dstore (dstore),
      .dwait  (dwait),
      .flushed(flushed)
   );

   function automatic dcache_pkg::word_t initial_word(input dcache_pkg::word_t addr);
      return addr ^ MEM_PATTERN;
   endfunction

   // what the memory model holds at an address
   function automatic dcache_pkg::word_t memory_word(input dcache_pkg::word_t addr);
      if (mem_words.exists(addr))
      begin
         return mem_words[addr];
      end
      return initial_word(addr);
   endfunction

   // what a processor read should return
   function automatic dcache_pkg::word_t expected_word(input dcache_pkg::word_t addr);
      if (shadow.exists(addr))
      begin
         return shadow[addr];
      end
      return initial_word(addr);
   endfunction

   task automatic check_word(input string name, input dcache_pkg::word_t expected,
                             input dcache_pkg::word_t actual);
      if (actual !== expected)
      begin
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
         $display("Verification failed");
         $fatal(1, "stopped at the first error");
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
         $display("Verification failed");
         $fatal(1, "stopped at the first error");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "stopped on a timeout");
   endtask

   task automatic add_step(input string name, input tb_op_e op, input dcache_pkg::word_t addr,
                           input dcache_pkg::word_t data, input logic mem);
      step_name.push_back(name);
      step_op.push_back(op);
      step_addr.push_back(addr);
      step_data.push_back(data);
      step_mem.push_back(mem);
   endtask

   // processor read or write, held until dhit
   task automatic run_access(input int i);
      int cycles;
      logic mem_seen;
      cycles = 0;
      mem_seen = 1'b0;
      dmemREN = (step_op[i] == OP_READ);
      dmemWEN = (step_op[i] == OP_WRITE);
      dmemaddr = step_addr[i];
      dmemstore = step_data[i];
      @(negedge CLK);
      while (!dhit)
      begin
         if (dREN || dWEN)
         begin
            mem_seen = 1'b1;
         end
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
         begin
            report_timeout({step_name[i], " dhit"});
         end
         @(negedge CLK);
      end
      if (step_op[i] == OP_WRITE)
      begin
         shadow[step_addr[i]] = step_data[i];
      end
      else
      begin
         check_word({step_name[i], " read data"}, expected_word(step_addr[i]), dmemload);
      end
      check_flag({step_name[i], " memory access"}, step_mem[i], mem_seen);
      // the hit completes at this edge, then the request drops
      @(posedge CLK);
      #1;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
   endtask

   // halt, wait for flushed, then compare memory with the shadow image
   task automatic run_halt(input int i);
      int cycles;
      logic mem_seen;
      cycles = 0;
      mem_seen = 1'b0;
      halt = 1'b1;
      @(negedge CLK);
      while (!flushed)
      begin
         // dirty blocks go out to memory during the scan
         if (dREN || dWEN)
         begin
            mem_seen = 1'b1;
         end
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
         begin
            report_timeout({step_name[i], " flushed"});
         end
         @(negedge CLK);
      end
      check_flag({step_name[i], " memory access"}, step_mem[i], mem_seen);
      check_flag({step_name[i], " memory idle"}, 1'b0, dREN || dWEN);
      foreach (shadow[a])
      begin
         check_word($sformatf("%s memory at %h", step_name[i], a),
                    shadow[a], memory_word(a));
      end
   endtask

   initial
   begin
      CLK = 1'b0;
      forever
      begin
         #5 CLK = ~CLK;
      end
   end

   // memory model, 0 to 3 wait cycles per word
   initial
   begin
      int wait_left;
      logic busy;
      void'($urandom(93));
      wait_left = 0;
      busy = 1'b0;
      dwait = 1'b1;
      dload = '0;
      forever
      begin
         @(posedge CLK);
         #1;
         if (!(dREN || dWEN))
         begin
            busy = 1'b0;
            dwait = 1'b1;
         end
         else
         begin
            // new word, draw its latency
            if (!busy)
            begin
               busy = 1'b1;
               wait_left = $urandom % 4;
            end
            if (wait_left == 0)
            begin
               // word completes at the next rising edge
               dwait = 1'b0;
               dload = memory_word(daddr);
               if (dWEN)
               begin
                  mem_words[daddr] = dstore;
               end
               busy = 1'b0;
            end
            else
            begin
               dwait = 1'b1;
               wait_left--;
            end
         end
      end
   end

   initial
   begin
      nRST = 1'b0;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
      halt = 1'b0;
      dmemaddr = '0;
      dmemstore = '0;

      // fresh miss, then a hit on the same block
      add_step("read_miss_fresh", OP_READ, 32'h0000_1000, '0, 1'b1);
      add_step("reread_hit", OP_READ, 32'h0000_1000, '0, 1'b0);
      add_step("write_hit", OP_WRITE, 32'h0000_1004, 32'hCAFE_0001, 1'b0);
      add_step("read_after_write", OP_READ, 32'h0000_1004, '0, 1'b0);
      // three tags in set 1, the third forces a dirty eviction
      add_step("evict_write_a", OP_WRITE, 32'h0000_2008, 32'h1111_0001, 1'b1);
      add_step("evict_write_b", OP_WRITE, 32'h0000_3008, 32'h2222_0002, 1'b1);
      add_step("evict_write_c", OP_WRITE, 32'h0000_4008, 32'h3333_0003, 1'b1);
      add_step("evict_read_a", OP_READ, 32'h0000_2008, '0, 1'b1);
      add_step("evict_read_b", OP_READ, 32'h0000_3008, '0, 1'b1);
      add_step("evict_read_c", OP_READ, 32'h0000_4008, '0, 1'b1);
      // A, B, A, C in set 2 leaves A resident and B evicted
      add_step("lru_read_a", OP_READ, 32'h0000_5010, '0, 1'b1);
      add_step("lru_read_b", OP_READ, 32'h0000_6010, '0, 1'b1);
      add_step("lru_reread_a", OP_READ, 32'h0000_5010, '0, 1'b0);
      add_step("lru_read_c", OP_READ, 32'h0000_7010, '0, 1'b1);
      add_step("lru_hit_a", OP_READ, 32'h0000_5010, '0, 1'b0);
      add_step("lru_miss_b", OP_READ, 32'h0000_6010, '0, 1'b1);
      add_step("write_before_halt", OP_WRITE, 32'h0000_5014, 32'h4444_0004, 1'b0);
      add_step("halt_flush", OP_HALT, '0, '0, 1'b1);

      repeat (4) @(posedge CLK);
      #1;
      nRST = 1'b1;

      for (int i = 0; i < step_name.size(); i++)
      begin
         if (step_op[i] == OP_HALT)
         begin
            run_halt(i);
         end
         else
         begin
            run_access(i);
         end
      end

      $display("Verification passed");
      $finish;
   end

endmodule

/* dcache.f */
+incdir+common
common/dcache_pkg.sv
common/cache_array_if.sv
dcache/dcache_store.sv
dcache/dcache_lookup.sv
dcache/dcache_controller.sv
design/dcache.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

/* Makefile */
# Verilator build and run of the data cache testbench
VERILATOR ?= verilator
TOP ?= dcache_tb
FILELIST ?= dcache.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
